//--- common/lsu_pkg.sv
package lsu_pkg;

	// rv32 major opcodes
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	localparam logic [31:0] SRAM_BASE  = 32'h0f00_0000;
	localparam logic [31:0] SRAM_BYTES = 32'd8192;
	localparam logic [31:0] WIN_BASE   = 32'h8000_0000;
	localparam logic [31:0] WIN_BYTES  = 32'd4096;

	typedef struct packed {
		logic [6:0]  opcode;
		logic [2:0]  funct3;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] imm;
		logic [7:0]  wmask; // byte enables before lane shift
	} lsu_req_t;

	typedef struct packed {
		logic [31:0] addr;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} axi_r_t;

	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage

//--- lsu/lsu_load_align.sv
module lsu_load_align (
	input  logic [63:0] rdata,
	input  logic [2:0]  offset,
	input  logic        in_dword,
	input  logic        in_word,
	input  logic [2:0]  funct3,
	output logic [31:0] value
);
	import lsu_pkg::*;

	logic [63:0] shifted;
	logic [31:0] sel;

	always_comb begin
		if (in_dword)
			shifted = rdata >> {offset, 3'b000}; // zero fill from the top
		else if (in_word)
			shifted = rdata >> {offset[1:0], 3'b000};
		else
			shifted = rdata;
	end

	assign sel = shifted[31:0];

	always_comb begin
		case (funct3)
			F3_B:    value = {{24{sel[7]}}, sel[7:0]};
			F3_H:    value = {{16{sel[15]}}, sel[15:0]};
			F3_W:    value = sel;
			F3_BU:   value = {24'b0, sel[7:0]};
			F3_HU:   value = {16'b0, sel[15:0]};
			default: value = '0;
		endcase
	end

endmodule

//--- lsu/lsu_store_align.sv
module lsu_store_align (
	input  logic [31:0] src2,
	input  logic [7:0]  wmask,
	input  logic [2:0]  offset,
	output logic [63:0] wdata,
	output logic [7:0]  wstrb
);

	logic [63:0] data_wide;

	assign data_wide = {32'b0, src2};

	// bytes pushed past lane 7 fall off
	assign wdata = data_wide << {offset, 3'b000};
	assign wstrb = wmask << offset;

endmodule

//--- lsu/lsu.sv
module lsu #(
	parameter logic [31:0] SRAM_BASE  = lsu_pkg::SRAM_BASE,
	parameter logic [31:0] SRAM_BYTES = lsu_pkg::SRAM_BYTES,
	parameter logic [31:0] WIN_BASE   = lsu_pkg::WIN_BASE,
	parameter logic [31:0] WIN_BYTES  = lsu_pkg::WIN_BYTES
)(
	input  logic              clock,
	input  logic              arst_n,

	input  lsu_pkg::lsu_req_t req,
	input  logic              ren,
	input  logic              wen,
	input  logic              wb_valid,

	output lsu_pkg::axi_ar_t  ar,
	output logic              arvalid,
	input  logic              arready,
	input  lsu_pkg::axi_r_t   r,
	input  logic              rvalid,
	output logic              rready,

	output lsu_pkg::axi_aw_t  aw,
	output logic              awvalid,
	input  logic              awready,
	output lsu_pkg::axi_w_t   w,
	output logic              wvalid,
	input  logic              wready,
	input  lsu_pkg::axi_b_t   b,
	input  logic              bvalid,
	output logic              bready,

	output logic [31:0]       lsu_val,
	output logic              load_done,
	output logic              store_done
);
	import lsu_pkg::*;

	logic [31:0] addr;
	logic        in_dword;
	logic        in_word;
	logic [31:0] load_value;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        r_fire;

	assign addr = req.src1 + req.imm;

	// unsigned offset compare covers both bounds
	assign in_dword = (addr - SRAM_BASE) < SRAM_BYTES;
	assign in_word  = (addr - WIN_BASE) < WIN_BYTES;

	lsu_load_align u_load_align (
		.rdata   (r.data),
		.offset  (addr[2:0]),
		.in_dword(in_dword),
		.in_word (in_word),
		.funct3  (req.funct3),
		.value   (load_value)
	);

	lsu_store_align u_store_align (
		.src2  (req.src2),
		.wmask (req.wmask),
		.offset(addr[2:0]),
		.wdata (wdata),
		.wstrb (wstrb)
	);

	assign ar = '{addr: addr};
	assign aw = '{addr: addr};
	assign w  = '{data: wdata, strb: wstrb};

	assign rready = 1'b1;
	assign bready = 1'b1;

	assign r_fire     = rvalid & rready;
	assign load_done  = r_fire;
	assign store_done = bvalid & bready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			arvalid <= (arvalid & ~arready) | (~arvalid & ren);
			awvalid <= (awvalid & ~awready) | (~awvalid & wen);
			wvalid  <= (wvalid & ~wready) | (~wvalid & wen);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			lsu_val <= '0;
		end else if (wb_valid) begin
			lsu_val <= '0; // consumed by writeback
		end else if (r_fire) begin
			if (req.opcode == OP_LOAD && r.resp == RESP_OKAY)
				lsu_val <= load_value;
			else
				lsu_val <= '0;
		end
	end

endmodule

//--- verilog/axi_decoder.sv
module axi_decoder #(
	parameter logic [31:0] SRAM_BASE  = lsu_pkg::SRAM_BASE,
	parameter logic [31:0] SRAM_BYTES = lsu_pkg::SRAM_BYTES,
	parameter logic [31:0] WIN_BASE   = lsu_pkg::WIN_BASE,
	parameter logic [31:0] WIN_BYTES  = lsu_pkg::WIN_BYTES
)(
	input  logic             clock,
	input  logic             arst_n,

	input  lsu_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	output lsu_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,
	input  lsu_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  lsu_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output lsu_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready,

	output lsu_pkg::axi_ar_t s0_ar,
	output logic             s0_arvalid,
	input  logic             s0_arready,
	input  lsu_pkg::axi_r_t  s0_r,
	input  logic             s0_rvalid,
	output logic             s0_rready,
	output lsu_pkg::axi_aw_t s0_aw,
	output logic             s0_awvalid,
	input  logic             s0_awready,
	output lsu_pkg::axi_w_t  s0_w,
	output logic             s0_wvalid,
	input  logic             s0_wready,
	input  lsu_pkg::axi_b_t  s0_b,
	input  logic             s0_bvalid,
	output logic             s0_bready,

	output lsu_pkg::axi_ar_t s1_ar,
	output logic             s1_arvalid,
	input  logic             s1_arready,
	input  lsu_pkg::axi_r_t  s1_r,
	input  logic             s1_rvalid,
	output logic             s1_rready,
	output lsu_pkg::axi_aw_t s1_aw,
	output logic             s1_awvalid,
	input  logic             s1_awready,
	output lsu_pkg::axi_w_t  s1_w,
	output logic             s1_wvalid,
	input  logic             s1_wready,
	input  lsu_pkg::axi_b_t  s1_b,
	input  logic             s1_bvalid,
	output logic             s1_bready
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {TGT_S0, TGT_S1, TGT_ERR} tgt_e;

	tgt_e ar_tgt;
	tgt_e aw_tgt;
	tgt_e w_tgt;
	tgt_e rd_tgt_q;
	tgt_e wr_tgt_q;
	logic err_rvalid_q;
	logic err_bvalid_q;

	function automatic tgt_e decode(input logic [31:0] addr);
		if (addr - SRAM_BASE < SRAM_BYTES)
			return TGT_S0;
		else if (addr - WIN_BASE < WIN_BYTES)
			return TGT_S1;
		else
			return TGT_ERR;
	endfunction

	assign ar_tgt = decode(ar.addr);
	assign aw_tgt = decode(aw.addr);
	assign w_tgt  = awvalid ? aw_tgt : wr_tgt_q; // aw may already be gone

	assign s0_ar = ar;
	assign s1_ar = ar;
	assign s0_aw = aw;
	assign s1_aw = aw;
	assign s0_w  = w;
	assign s1_w  = w;

	assign s0_arvalid = arvalid && ar_tgt == TGT_S0;
	assign s1_arvalid = arvalid && ar_tgt == TGT_S1;
	assign s0_awvalid = awvalid && aw_tgt == TGT_S0;
	assign s1_awvalid = awvalid && aw_tgt == TGT_S1;
	assign s0_wvalid  = wvalid && w_tgt == TGT_S0;
	assign s1_wvalid  = wvalid && w_tgt == TGT_S1;

	assign s0_rready = rready && rd_tgt_q == TGT_S0;
	assign s1_rready = rready && rd_tgt_q == TGT_S1;
	assign s0_bready = bready && wr_tgt_q == TGT_S0;
	assign s1_bready = bready && wr_tgt_q == TGT_S1;

	always_comb begin
		case (ar_tgt)
			TGT_S0:  arready = s0_arready;
			TGT_S1:  arready = s1_arready;
			default: arready = !err_rvalid_q;
		endcase
		// unmapped aw and w are taken in the same cycle
		case (aw_tgt)
			TGT_S0:  awready = s0_awready;
			TGT_S1:  awready = s1_awready;
			default: awready = wvalid && !err_bvalid_q;
		endcase
		case (w_tgt)
			TGT_S0:  wready = s0_wready;
			TGT_S1:  wready = s1_wready;
			default: wready = awvalid && !err_bvalid_q;
		endcase
	end

	always_comb begin
		case (rd_tgt_q)
			TGT_S0: begin
				r      = s0_r;
				rvalid = s0_rvalid;
			end
			TGT_S1: begin
				r      = s1_r;
				rvalid = s1_rvalid;
			end
			default: begin
				r      = '{data: '0, resp: RESP_DECERR};
				rvalid = err_rvalid_q;
			end
		endcase
		case (wr_tgt_q)
			TGT_S0: begin
				b      = s0_b;
				bvalid = s0_bvalid;
			end
			TGT_S1: begin
				b      = s1_b;
				bvalid = s1_bvalid;
			end
			default: begin
				b      = '{resp: RESP_DECERR};
				bvalid = err_bvalid_q;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_tgt_q     <= TGT_ERR;
			wr_tgt_q     <= TGT_ERR;
			err_rvalid_q <= 1'b0;
			err_bvalid_q <= 1'b0;
		end else begin
			if (arvalid && arready)
				rd_tgt_q <= ar_tgt;
			if (awvalid && awready)
				wr_tgt_q <= aw_tgt;

			if (arvalid && arready && ar_tgt == TGT_ERR)
				err_rvalid_q <= 1'b1;
			else if (rready)
				err_rvalid_q <= 1'b0;

			if (awvalid && awready && aw_tgt == TGT_ERR)
				err_bvalid_q <= 1'b1;
			else if (bready)
				err_bvalid_q <= 1'b0;
		end
	end

endmodule

//--- verilog/axi_ram.sv
module axi_ram #(
	parameter logic [31:0] BASE          = 32'h0,
	parameter logic [31:0] BYTES         = 32'd4096,
	parameter int          GRANULE_BYTES = 8
)(
	input  logic             clock,
	input  logic             arst_n,

	input  lsu_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	output lsu_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,

	input  lsu_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  lsu_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output lsu_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready
);
	import lsu_pkg::*;

	// BYTES is a power of two, so the low bits give the offset modulo BYTES
	localparam int            AW         = $clog2(BYTES);
	localparam logic [AW-1:0] GRAN_MASK  = ~AW'(GRANULE_BYTES - 1);
	localparam logic [AW-1:0] DWORD_MASK = ~AW'(7);

	logic [7:0]    mem [BYTES];
	logic [63:0]   rdata_q;
	logic          rvalid_q;
	logic          bvalid_q;
	logic          aw_got_q;
	logic          w_got_q;
	logic [AW-1:0] aw_idx_q;
	logic [63:0]   wdata_q;
	logic [7:0]    wstrb_q;

	logic [31:0]   ar_off;
	logic [31:0]   aw_off;
	logic [AW-1:0] rd_idx;
	logic [AW-1:0] aw_idx;
	logic [AW-1:0] wr_idx;
	logic [63:0]   wr_data;
	logic [7:0]    wr_strb;
	logic          ar_fire;
	logic          aw_fire;
	logic          w_fire;
	logic          wr_go;

	assign ar_off = ar.addr - BASE;
	assign aw_off = aw.addr - BASE;
	assign rd_idx = ar_off[AW-1:0] & GRAN_MASK;
	assign aw_idx = aw_off[AW-1:0] & DWORD_MASK;

	assign arready = !rvalid_q;
	assign awready = !bvalid_q && !aw_got_q;
	assign wready  = !bvalid_q && !w_got_q;

	assign ar_fire = arvalid && arready;
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	// write once both halves are in, this cycle or earlier
	assign wr_go   = (aw_fire || aw_got_q) && (w_fire || w_got_q);
	assign wr_idx  = aw_got_q ? aw_idx_q : aw_idx;
	assign wr_data = w_got_q ? wdata_q : w.data;
	assign wr_strb = w_got_q ? wstrb_q : w.strb;

	assign r      = '{data: rdata_q, resp: RESP_OKAY};
	assign rvalid = rvalid_q;
	assign b      = '{resp: RESP_OKAY};
	assign bvalid = bvalid_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
			aw_got_q <= 1'b0;
			w_got_q  <= 1'b0;
		end else begin
			if (ar_fire)
				rvalid_q <= 1'b1;
			else if (rready)
				rvalid_q <= 1'b0;

			if (wr_go)
				bvalid_q <= 1'b1;
			else if (bready)
				bvalid_q <= 1'b0;

			if (wr_go)
				aw_got_q <= 1'b0;
			else if (aw_fire)
				aw_got_q <= 1'b1;

			if (wr_go)
				w_got_q <= 1'b0;
			else if (w_fire)
				w_got_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			for (int i = 0; i < 8; i++)
				rdata_q[8*i +: 8] <= mem[rd_idx + AW'(i)]; // wraps at window end
		end
		if (aw_fire)
			aw_idx_q <= aw_idx;
		if (w_fire) begin
			wdata_q <= w.data;
			wstrb_q <= w.strb;
		end
		if (wr_go) begin
			for (int i = 0; i < 8; i++)
				if (wr_strb[i])
					mem[wr_idx + AW'(i)] <= wr_data[8*i +: 8];
		end
	end

endmodule

//--- verilog/mem_subsys_top.sv
module mem_subsys_top (
	input  logic              clock,
	input  logic              arst_n,
	input  lsu_pkg::lsu_req_t req,
	input  logic              ren,
	input  logic              wen,
	input  logic              wb_valid,
	output logic [31:0]       lsu_val,
	output logic              load_done,
	output logic              store_done
);
	import lsu_pkg::*;

	// upstream, lsu side of the decoder
	axi_ar_t ar;
	axi_r_t  r;
	axi_aw_t aw;
	axi_w_t  w;
	axi_b_t  b;
	logic    arvalid, arready, rvalid, rready;
	logic    awvalid, awready, wvalid, wready, bvalid, bready;

	// s0 is the sram, s1 the word window
	axi_ar_t s0_ar, s1_ar;
	axi_r_t  s0_r, s1_r;
	axi_aw_t s0_aw, s1_aw;
	axi_w_t  s0_w, s1_w;
	axi_b_t  s0_b, s1_b;
	logic    s0_arvalid, s0_arready, s0_rvalid, s0_rready;
	logic    s0_awvalid, s0_awready, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
	logic    s1_arvalid, s1_arready, s1_rvalid, s1_rready;
	logic    s1_awvalid, s1_awready, s1_wvalid, s1_wready, s1_bvalid, s1_bready;

	lsu #(
		.SRAM_BASE (SRAM_BASE),
		.SRAM_BYTES(SRAM_BYTES),
		.WIN_BASE  (WIN_BASE),
		.WIN_BYTES (WIN_BYTES)
	) u_lsu (
		.clock, .arst_n, .req, .ren, .wen, .wb_valid,
		.ar, .arvalid, .arready, .r, .rvalid, .rready,
		.aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
		.lsu_val, .load_done, .store_done
	);

	axi_decoder #(
		.SRAM_BASE (SRAM_BASE),
		.SRAM_BYTES(SRAM_BYTES),
		.WIN_BASE  (WIN_BASE),
		.WIN_BYTES (WIN_BYTES)
	) u_decoder (
		.clock, .arst_n,
		.ar, .arvalid, .arready, .r, .rvalid, .rready,
		.aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
		.s0_ar, .s0_arvalid, .s0_arready, .s0_r, .s0_rvalid, .s0_rready,
		.s0_aw, .s0_awvalid, .s0_awready, .s0_w, .s0_wvalid, .s0_wready,
		.s0_b, .s0_bvalid, .s0_bready,
		.s1_ar, .s1_arvalid, .s1_arready, .s1_r, .s1_rvalid, .s1_rready,
		.s1_aw, .s1_awvalid, .s1_awready, .s1_w, .s1_wvalid, .s1_wready,
		.s1_b, .s1_bvalid, .s1_bready
	);

	axi_ram #(
		.BASE         (SRAM_BASE),
		.BYTES        (SRAM_BYTES),
		.GRANULE_BYTES(8) // whole doubleword
	) sram0 (
		.clock, .arst_n,
		.ar(s0_ar), .arvalid(s0_arvalid), .arready(s0_arready),
		.r(s0_r), .rvalid(s0_rvalid), .rready(s0_rready),
		.aw(s0_aw), .awvalid(s0_awvalid), .awready(s0_awready),
		.w(s0_w), .wvalid(s0_wvalid), .wready(s0_wready),
		.b(s0_b), .bvalid(s0_bvalid), .bready(s0_bready)
	);

	axi_ram #(
		.BASE         (WIN_BASE),
		.BYTES        (WIN_BYTES),
		.GRANULE_BYTES(4) // 8 bytes from the aligned word
	) win0 (
		.clock, .arst_n,
		.ar(s1_ar), .arvalid(s1_arvalid), .arready(s1_arready),
		.r(s1_r), .rvalid(s1_rvalid), .rready(s1_rready),
		.aw(s1_aw), .awvalid(s1_awvalid), .awready(s1_awready),
		.w(s1_w), .wvalid(s1_wvalid), .wready(s1_wready),
		.b(s1_b), .bvalid(s1_bvalid), .bready(s1_bready)
	);

endmodule

//--- testbench/tb_mem_subsys.sv
module tb_mem_subsys;
	import lsu_pkg::*;

	localparam int PERIOD       = 4;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES  = 10;
	localparam int INSTR_CYCLES = 200; // budget per instruction
	localparam int AREA_WORDS   = 64; // prefilled bytes per region, in words
	localparam logic [31:0] AREA = 32'(4 * AREA_WORDS);
	localparam int N_PREFILL = 2 * AREA_WORDS;
	localparam int N_SRAM_RT = 3 * 8 * 6;
	localparam int N_WIN_RT  = 2 * 3 * 4 * 6;
	localparam int N_UNMAP   = 2 * 3;
	localparam int N_WB      = 2;
	localparam int N_RANDOM  = 300;
	localparam int N_PLANNED = N_PREFILL + N_SRAM_RT + N_WIN_RT + N_UNMAP + N_WB + N_RANDOM;
	localparam int SRAM_N  = int'(SRAM_BYTES);
	localparam int WIN_N   = int'(WIN_BYTES);
	localparam int SRAM_AW = $clog2(SRAM_N);
	localparam int WIN_AW  = $clog2(WIN_N);

	logic        clock;
	logic        arst_n;
	lsu_req_t    req;
	logic        ren;
	logic        wen;
	logic        wb_valid;
	logic [31:0] lsu_val;
	logic        load_done;
	logic        store_done;

	logic [7:0] sram_m [SRAM_N];
	logic [7:0] win_m [WIN_N];

	int    errors;
	int    checks;
	int    issued;
	int    tests_run;
	int    tests_bad;
	int    errs_at_open;
	string test_name;

	mem_subsys_top dut0 (
		.clock     (clock),
		.arst_n    (arst_n),
		.req       (req),
		.ren       (ren),
		.wen       (wen),
		.wb_valid  (wb_valid),
		.lsu_val   (lsu_val),
		.load_done (load_done),
		.store_done(store_done)
	);

	always #(PERIOD / 2) clock = ~clock;

	function automatic logic in_sram(input logic [31:0] a);
		return (a - SRAM_BASE) < SRAM_BYTES;
	endfunction

	function automatic logic in_win(input logic [31:0] a);
		return (a - WIN_BASE) < WIN_BYTES;
	endfunction

	function automatic logic [7:0] read_byte(input logic [31:0] a);
		logic [31:0] off;
		off = in_sram(a) ? a - SRAM_BASE : a - WIN_BASE;
		if (in_sram(a))
			return sram_m[off[SRAM_AW-1:0]];
		else if (in_win(a))
			return win_m[off[WIN_AW-1:0]];
		return 8'h00;
	endfunction

	function automatic void write_byte(input logic [31:0] a, input logic [7:0] value);
		logic [31:0] off;
		off = in_sram(a) ? a - SRAM_BASE : a - WIN_BASE;
		if (in_sram(a))
			sram_m[off[SRAM_AW-1:0]] = value;
		else if (in_win(a))
			win_m[off[WIN_AW-1:0]] = value;
	endfunction

	// every address byte takes part
	function automatic logic [7:0] fill_byte(input logic [31:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h96;
	endfunction

	function automatic logic [31:0] extend(input logic [31:0] raw, input logic [2:0] f3);
		case (f3)
			F3_B:    return {{24{raw[7]}}, raw[7:0]};
			F3_H:    return {{16{raw[15]}}, raw[15:0]};
			F3_W:    return raw;
			F3_BU:   return {24'h0, raw[7:0]};
			F3_HU:   return {16'h0, raw[15:0]};
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [2:0] f3);
		logic [31:0] raw;
		raw = 32'h0;
		for (int i = 0; i < 4; i++) begin
			// sram data stops at the end of the dword
			if (in_win(a) || (in_sram(a) && int'(a[2:0]) + i < 8))
				raw[8*i +: 8] = read_byte(a + 32'(i));
		end
		return extend(raw, f3);
	endfunction

	function automatic void record_store(input logic [31:0] a, input logic [31:0] data,
			input logic [7:0] mask);
		for (int i = 0; i < 4; i++) begin
			if (mask[i] && int'(a[2:0]) + i < 8) // lanes past 7 are lost
				write_byte(a + 32'(i), data[8*i +: 8]);
		end
	endfunction

	function automatic logic [2:0] store_code(input int unsigned s);
		if (s == 0)
			return F3_W;
		else if (s == 1)
			return F3_H;
		return F3_B;
	endfunction

	function automatic logic [2:0] load_code(input int unsigned l);
		if (l == 0)
			return F3_B;
		else if (l == 1)
			return F3_H;
		else if (l == 2)
			return F3_W;
		else if (l == 3)
			return F3_BU;
		return F3_HU;
	endfunction

	function automatic logic [7:0] byte_mask(input logic [2:0] f3);
		if (f3 == F3_B)
			return 8'h01;
		else if (f3 == F3_H)
			return 8'h03;
		return 8'h0f;
	endfunction

	function automatic logic [31:0] random_addr(input int unsigned region);
		logic [31:0] r;
		r = $urandom();
		if (region == 0)
			return SRAM_BASE + r % (AREA - 32'd8);
		else if (region == 1)
			return WIN_BASE + r % (AREA - 32'd8);
		else if (r[31])
			return SRAM_BASE + SRAM_BYTES + r % AREA; // aliases the sram if decoded wrong
		return 32'h4000_0000 + (r & 32'h0000_ffff);
	endfunction

	task automatic issue(input logic [6:0] op, input logic [2:0] f3, input logic [31:0] addr,
			input logic [31:0] data, input logic [7:0] mask, output logic ok);
		logic [31:0] r32;
		logic [31:0] imm;
		logic        is_load;
		int          waited;
		r32 = $urandom();
		imm = {{20{r32[11]}}, r32[11:0]};
		is_load = (op == OP_LOAD);
		@(negedge clock);
		req = '{opcode: op, funct3: f3, src1: addr - imm, src2: data, imm: imm, wmask: mask};
		ren = (op == OP_LOAD);
		wen = (op == OP_STORE);
		@(negedge clock);
		ren = 1'b0;
		wen = 1'b0;
		waited = 0;
		while (!(is_load ? load_done : store_done) && waited < INSTR_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		issued++;
		ok = is_load ? load_done : store_done;
		if (!ok) begin
			$display("error at %0t: no done strobe for opcode %b address %h", $time, op, addr);
			errors++;
		end
		@(negedge clock); // let the done edge pass
	endtask

	task automatic run_store(input logic [2:0] f3, input logic [31:0] addr,
			input logic [31:0] data);
		logic ok;
		record_store(addr, data, byte_mask(f3));
		issue(OP_STORE, f3, addr, data, byte_mask(f3), ok);
	endtask

	task automatic run_load(input logic [2:0] f3, input logic [31:0] addr);
		logic [31:0] expected;
		logic        ok;
		expected = expect_load(addr, f3);
		issue(OP_LOAD, f3, addr, $urandom(), 8'h00, ok);
		if (ok) begin
			checks++;
			assert (lsu_val === expected)
			else begin
				$display("mismatch at %0t: load f3 %b at %h gave %h, expected %h",
					$time, f3, addr, lsu_val, expected);
				errors++;
			end
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		errs_at_open = errors;
		tests_run++;
	endtask

	task automatic close_test();
		if (errors == errs_at_open) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - errs_at_open);
			tests_bad++;
		end
	endtask

	task automatic check_reset();
		open_test("reset");
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			checks++;
			assert (!load_done && !store_done)
			else begin
				$display("error at %0t: done strobe seen with no request", $time);
				errors++;
			end
		end
		checks++;
		assert (lsu_val === 32'h0)
		else begin
			$display("mismatch at %0t: lsu_val is %h after reset", $time, lsu_val);
			errors++;
		end
		close_test();
	endtask

	task automatic prefill();
		logic [31:0] a;
		open_test("prefill");
		for (int k = 0; k < 2 * AREA_WORDS; k++) begin
			a = (k < AREA_WORDS ? SRAM_BASE : WIN_BASE) + 32'(4 * (k % AREA_WORDS));
			run_store(F3_W, a, {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)});
		end
		close_test();
	endtask

	task automatic sram_round_trip();
		logic [31:0] a;
		open_test("sram round trip");
		for (int s = 0; s < 3; s++) begin
			for (int off = 0; off < 8; off++) begin
				a = SRAM_BASE + 32'h40 + 32'(off);
				run_store(store_code(s), a, $urandom());
				for (int l = 0; l < 5; l++)
					run_load(load_code(l), a);
			end
		end
		close_test();
	endtask

	task automatic window_round_trip();
		logic [31:0] a;
		open_test("window round trip");
		for (int wd = 0; wd < 2; wd++) begin
			for (int s = 0; s < 3; s++) begin
				for (int off = 0; off < 4; off++) begin
					a = WIN_BASE + 32'h40 + 32'(4 * wd + off);
					run_store(store_code(s), a, $urandom());
					for (int l = 0; l < 5; l++)
						run_load(load_code(l), a);
				end
			end
		end
		close_test();
	endtask

	task automatic unmapped_access();
		logic [31:0] alias_addr;
		open_test("unmapped");
		for (int k = 0; k < 2; k++) begin
			alias_addr = k == 0 ? SRAM_BASE + SRAM_BYTES + 32'h48 : WIN_BASE + WIN_BYTES + 32'h48;
			run_store(F3_W, alias_addr, 32'hdead_beef);
			run_load(F3_W, alias_addr);
			run_load(F3_W, alias_addr - (k == 0 ? SRAM_BYTES : WIN_BYTES)); // untouched
		end
		close_test();
	endtask

	task automatic writeback_clear();
		logic [31:0] a;
		open_test("writeback clear");
		a = SRAM_BASE + 32'h80;
		run_store(F3_W, a, 32'h8421_5a3c);
		run_load(F3_W, a);
		checks++;
		assert (lsu_val !== 32'h0)
		else begin
			$display("error at %0t: load before the writeback pulse returned zero", $time);
			errors++;
		end
		@(negedge clock);
		wb_valid = 1'b1;
		@(negedge clock);
		wb_valid = 1'b0;
		checks++;
		assert (lsu_val === 32'h0)
		else begin
			$display("mismatch at %0t: lsu_val %h not cleared by wb_valid", $time, lsu_val);
			errors++;
		end
		close_test();
	endtask

	task automatic random_mix();
		int unsigned region;
		logic [31:0] a;
		open_test("random mix");
		for (int n = 0; n < N_RANDOM; n++) begin
			region = $urandom % 3;
			a = random_addr(region);
			if ($urandom % 2 == 0)
				run_store(store_code($urandom % 3), a, $urandom());
			else
				run_load(load_code($urandom % 5), a);
		end
		close_test();
	endtask

	initial begin
		#(PERIOD * (RESET_CYCLES + IDLE_CYCLES + INSTR_CYCLES * N_PLANNED));
		$display("timeout: run did not finish in the cycle budget, %0d instructions issued",
			issued);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'ha49c));
		clock    = 1'b0;
		arst_n   = 1'b0;
		req      = '0;
		ren      = 1'b0;
		wen      = 1'b0;
		wb_valid = 1'b0;
		errors    = 0;
		checks    = 0;
		issued    = 0;
		tests_run = 0;
		tests_bad = 0;
		repeat (RESET_CYCLES) @(negedge clock);
		arst_n = 1'b1;

		check_reset();
		prefill();
		sram_round_trip();
		window_round_trip();
		unmapped_access();
		writeback_clear();
		random_mix();

		$display("tests %0d, tests with errors %0d, checks %0d, errors %0d, instructions %0d",
			tests_run, tests_bad, checks, errors, issued);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- all.f
common/lsu_pkg.sv
lsu/lsu_load_align.sv
lsu/lsu_store_align.sv
lsu/lsu.sv
verilog/axi_decoder.sv
verilog/axi_ram.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

//--- Makefile
# Verilator build for the load/store unit testbench
VERILATOR  ?= verilator
TOP        ?= tb_mem_subsys
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BINARY) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
